// File: bench/packet_stream_tb.sv
// Random testbench for the packet stream top level, run as the simulation top with the file list
`timescale 1ns/1ps

module packet_stream_tb;

	import packet_stream_pkg::*;

	typedef struct packed {
		ps_word_t word;
		logic last;
		ps_sum_t sum; // running frame sum including this word
	} expect_t;

	logic clk;
	logic reset;
	ps_word_t in_word;
	logic in_last;
	logic in_valid;
	logic in_ready;
	ps_word_t out_word;
	logic out_last;
	ps_sum_t out_sum;
	logic out_valid;
	logic out_ready;
	logic fifo_full;
	logic fifo_almost_full;
	logic fifo_empty;

	expect_t expect_q[$]; // words accepted but not yet seen at the output
	expect_t exp_out;
	ps_sum_t model_sum = '0;
	logic [15:0] lfsr_state = 16'd40055;
	logic in_take = 1'b0; // the input word is taken at the coming rising edge
	logic full_seen = 1'b0;
	logic almost_seen = 1'b0;
	int words_left = 0; // words the driver still has to offer
	int gap_cycles = 0;
	int ready_mode = 0; // 0 random, 1 held low, 2 held high
	logic use_gaps = 1'b0;
	int value_errors = 0;
	int other_errors = 0;
	int words_in = 0;
	int words_out = 0;

	packet_stream_top UUT (
		.clk(clk),
		.reset(reset),
		.in_word(in_word),
		.in_last(in_last),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_word(out_word),
		.out_last(out_last),
		.out_sum(out_sum),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.fifo_full(fifo_full),
		.fifo_almost_full(fifo_almost_full),
		.fifo_empty(fifo_empty)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	// one LFSR step per returned bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_word(input string name, input ps_word_t exp, input ps_word_t act);
		if (exp !== act) begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_sum(input string name, input ps_sum_t exp, input ps_sum_t act);
		if (exp !== act) begin
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("[FAIL] %0t ns %s expected %b got %b", $time, name, exp, act);
			value_errors++;
		end
	endtask

	// control changes and level checks land a quarter period after the edge
	task automatic step_cycle();
		@(posedge clk);
		#10;
	endtask

	function automatic logic drained();
		return words_left == 0 && !in_valid && expect_q.size() == 0;
	endfunction

	// drives input words and out_ready and makes every random draw in a fixed order
	always @(posedge clk) begin
		if (reset) begin
			in_valid <= 1'b0;
			out_ready <= 1'b0;
			gap_cycles = 0;
		end else begin
			if (!in_valid || in_take) begin
				if (gap_cycles > 0) begin
					in_valid <= 1'b0;
					gap_cycles--;
				end else if (words_left > 0) begin
					in_valid <= 1'b1;
					in_word <= take_bits(32);
					in_last <= (take_bits(8) < 43) || (words_left == 1); // a run ends its frame
					words_left--;
					if (use_gaps && take_bits(2) == 0) begin
						gap_cycles = take_bits(2) + 1;
					end
				end else begin
					in_valid <= 1'b0;
				end
			end
			case (ready_mode)
				0: out_ready <= (take_bits(2) != 0);
				1: out_ready <= 1'b0;
				default: out_ready <= 1'b1;
			endcase
		end
	end

	// handshakes are sampled on the falling edge where every level is settled
	always @(negedge clk) begin
		if (reset) begin
			in_take = 1'b0;
		end else begin
			in_take = in_valid && in_ready;
			if (in_take) begin
				model_sum = model_sum + in_word;
				expect_q.push_back({in_word, in_last, model_sum});
				if (in_last) begin
					model_sum = '0; // next frame starts from zero
				end
				words_in++;
			end
			if (out_valid && out_ready) begin
				if (expect_q.size() == 0) begin
					$display("output word %h at %0t ns has no matching input word", out_word, $time);
					other_errors++;
				end else begin
					exp_out = expect_q.pop_front();
					check_word("out_word", exp_out.word, out_word);
					check_flag("out_last", exp_out.last, out_last);
					check_sum("out_sum", exp_out.sum, out_sum);
				end
				words_out++;
			end
			if (fifo_full) begin
				full_seen = 1'b1;
			end
			if (fifo_almost_full) begin
				almost_seen = 1'b1;
			end
		end
	end

	initial begin
		int cycles;
		int stall;
		int start_in;
		logic ok;
		reset = 1'b1;
		in_word = '0;
		in_last = 1'b0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		ok = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		step_cycle();
		check_flag("out_valid", 1'b0, out_valid);
		check_flag("fifo_full", 1'b0, fifo_full);
		check_flag("fifo_almost_full", 1'b0, fifo_almost_full);
		check_flag("fifo_empty", 1'b1, fifo_empty);
		check_flag("in_ready", 1'b1, in_ready);

		// random words, frame ends, input gaps and output stalls
		ready_mode = 0;
		use_gaps = 1'b1;
		words_left = 400;
		cycles = 0;
		while (!drained() && cycles < 20000) begin
			step_cycle();
			cycles++;
		end
		if (!drained()) begin
			$display("timed out waiting for the random traffic to drain");
			other_errors++;
			ok = 1'b0;
		end

		// output held off until the whole path backs up
		if (ok) begin
			ready_mode = 1;
			use_gaps = 1'b0;
			words_left = 200;
			start_in = words_in;
			full_seen = 1'b0;
			almost_seen = 1'b0;
			stall = 0;
			cycles = 0;
			while (stall < 20 && cycles < 600) begin
				step_cycle();
				stall = (in_valid && !in_ready) ? stall + 1 : 0;
				cycles++;
			end
			if (stall < 20) begin
				$display("timed out waiting for in_ready to stay low under back-pressure");
				other_errors++;
				ok = 1'b0;
			end else if (words_in - start_in > 72) begin
				$display("%0d words were accepted with the output stalled, more than 72",
					words_in - start_in);
				other_errors++;
			end
			if (!full_seen) begin
				$display("the FIFO never reported full while the output was stalled");
				other_errors++;
			end
			if (!almost_seen) begin
				$display("the FIFO never reported almost full while it was filling");
				other_errors++;
			end
		end
		if (ok) begin
			words_left = 1; // one closing word ends the open frame
			ready_mode = 2;
			cycles = 0;
			while (!drained() && cycles < 2000) begin
				step_cycle();
				cycles++;
			end
			if (!drained()) begin
				$display("timed out waiting for the held words to drain");
				other_errors++;
			end else begin
				step_cycle();
				check_flag("fifo_empty", 1'b1, fifo_empty);
				check_flag("fifo_almost_full", 1'b0, fifo_almost_full);
				check_flag("out_valid", 1'b0, out_valid);
			end
		end

		$display("summary: %0d value errors, %0d other errors, %0d words in, %0d words out",
			value_errors, other_errors, words_in, words_out);
		if (value_errors == 0 && other_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: hdl/block_ram.sv
// Single-port synchronous RAM with registered read data, used as the line FIFO storage
`timescale 1ns/1ps
`include "packet_stream_macros.svh"

module block_ram #(
	parameter int ADDR_WIDTH = `PS_FIFO_ADDR_WIDTH,
	parameter int DATA_WIDTH = `PS_WORD_WIDTH,
	parameter int DEPTH = `PS_FIFO_DEPTH
)(
	input logic clk,
	input logic [ADDR_WIDTH-1:0] addr,
	input logic [DATA_WIDTH-1:0] wdata,
	input logic we,
	output logic [DATA_WIDTH-1:0] rdata
);

	logic [DATA_WIDTH-1:0] mem [DEPTH]; // storage array, no reset

	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata; // write on the shared address
		end
		rdata <= mem[addr]; // read first, so a write cycle returns the old entry
	end

endmodule

// File: hdl/line_fifo.sv
// FIFO of line entries over a single-port RAM with valid/ready on both sides, sized by the top level
`timescale 1ns/1ps
`include "packet_stream_macros.svh"

module line_fifo #(
	parameter int ADDR_WIDTH = `PS_FIFO_ADDR_WIDTH,
	parameter int DATA_WIDTH = packet_stream_pkg::PS_LINE_BITS,
	parameter int DEPTH = `PS_FIFO_DEPTH
)(
	input logic clk,
	input logic reset,

	// write side
	input logic [DATA_WIDTH-1:0] push_line,
	input logic push_valid,
	output logic push_ready,

	// read side
	output logic [DATA_WIDTH-1:0] pop_line,
	output logic pop_valid,
	input logic pop_ready,

	// fill levels
	output logic fifo_full,
	output logic fifo_almost_full,
	output logic fifo_empty
);

	logic [ADDR_WIDTH-1:0] write_ptr;
	logic [ADDR_WIDTH-1:0] read_ptr;
	logic [ADDR_WIDTH-1:0] write_ptr_next;
	logic [ADDR_WIDTH-1:0] read_ptr_next;
	logic [ADDR_WIDTH-1:0] ram_addr;
	logic [DATA_WIDTH-1:0] ram_rdata;

	logic pop_fire; // a line leaves this cycle
	logic concurrent; // push and pop in the same cycle
	logic has_data; // at least one entry stored
	logic is_full; // every entry stored

	block_ram #(
		.ADDR_WIDTH(ADDR_WIDTH),
		.DATA_WIDTH(DATA_WIDTH),
		.DEPTH(DEPTH)
	) u_ram (
		.clk(clk),
		.addr(ram_addr),
		.wdata(push_line),
		.we(push_ready),
		.rdata(ram_rdata)
	);

	// pointers wrap at DEPTH, which need not be a power of two
	assign write_ptr_next = (write_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
	assign read_ptr_next = (read_ptr == ADDR_WIDTH'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;

	assign push_ready = push_valid && !is_full; // a push happens whenever this is high
	assign pop_fire = pop_valid && pop_ready;
	assign concurrent = push_ready && pop_fire;

	assign ram_addr = push_ready ? write_ptr : read_ptr; // the write takes the port
	assign pop_line = ram_rdata;

	assign fifo_full = is_full;
	assign fifo_almost_full = (write_ptr_next == read_ptr);
	assign fifo_empty = !has_data;

	// pointers and fill flags
	always_ff @(posedge clk) begin
		if (reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			has_data <= 1'b0;
			is_full <= 1'b0;
		end else begin
			if (push_ready) begin
				write_ptr <= write_ptr_next;
				has_data <= 1'b1;
				if (fifo_almost_full) begin
					is_full <= 1'b1; // this push takes the last free entry
				end
			end

			// a pop after a push wins the flags, so a concurrent pair keeps the level
			if (pop_fire) begin
				read_ptr <= read_ptr_next;
				is_full <= 1'b0;
				if (read_ptr_next == write_ptr && !concurrent) begin
					has_data <= 1'b0; // the only entry just left
				end
			end
		end
	end

	// The RAM output follows read_ptr one cycle after a cycle with no write,
	// so pop_valid is raised only after such a cycle and dropped on any
	// access that moves a pointer or steals the port.
	always_ff @(posedge clk) begin
		if (reset) begin
			pop_valid <= 1'b0;
		end else if (pop_fire || push_ready) begin
			pop_valid <= 1'b0;
		end else if (has_data) begin
			pop_valid <= 1'b1; // read data of this cycle is the head entry
		end
	end

endmodule

// File: hdl/packet_stream_macros.svh
// Width and depth constants for the packet stream design, included by the package and RTL modules
`ifndef PACKET_STREAM_MACROS_SVH
`define PACKET_STREAM_MACROS_SVH

// bits in one data word
`define PS_WORD_WIDTH 32

// words gathered into one FIFO line entry
`define PS_LANES 4

// address bits of the line FIFO RAM
`define PS_FIFO_ADDR_WIDTH 4

// line entries held by the FIFO, must fit the address width
`define PS_FIFO_DEPTH 16

`endif

// File: hdl/packet_stream_pkg.sv
// Shared data types of the packet stream design, imported by the packer, unpacker and top level
`include "packet_stream_macros.svh"

package packet_stream_pkg;

	// one data word as it enters and leaves the design
	typedef logic [`PS_WORD_WIDTH-1:0] ps_word_t;

	// modulo 2^32 running sum of the words of a frame
	typedef logic [31:0] ps_sum_t;

	// one FIFO entry holding up to four words of a frame
	typedef struct packed {
		ps_word_t [`PS_LANES-1:0] lanes; // lane 0 is the first word in time
		logic [$clog2(`PS_LANES)-1:0] count; // valid lanes minus one
		logic last; // this line closes a frame
	} ps_line_t;

	// the FIFO stores lines as plain vectors of this width
	localparam int PS_LINE_BITS = $bits(ps_line_t);

	// packer: collecting words, or offering a finished line to the FIFO
	typedef enum logic {
		PACK_FILL,
		PACK_PUSH
	} pack_state_t;

	// unpacker: waiting for a line, or handing out its words
	typedef enum logic {
		UNPACK_IDLE,
		UNPACK_EMIT
	} unpack_state_t;

endpackage

// File: hdl/packet_stream_top.sv
// Top level of the packet stream, connecting the word packer, line FIFO and word unpacker
`timescale 1ns/1ps
`include "packet_stream_macros.svh"

module packet_stream_top (
	input logic clk,
	input logic reset,

	// word input
	input packet_stream_pkg::ps_word_t in_word,
	input logic in_last,
	input logic in_valid,
	output logic in_ready,

	// word output
	output packet_stream_pkg::ps_word_t out_word,
	output logic out_last,
	output packet_stream_pkg::ps_sum_t out_sum,
	output logic out_valid,
	input logic out_ready,

	// FIFO levels
	output logic fifo_full,
	output logic fifo_almost_full,
	output logic fifo_empty
);

	import packet_stream_pkg::*;

	ps_line_t push_line;
	logic push_valid;
	logic push_ready;
	ps_line_t pop_line;
	logic pop_valid;
	logic pop_ready;

	word_packer u_packer (
		.clk(clk),
		.reset(reset),
		.in_word(in_word),
		.in_last(in_last),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.push_line(push_line),
		.push_valid(push_valid),
		.push_ready(push_ready)
	);

	line_fifo #(
		.ADDR_WIDTH(`PS_FIFO_ADDR_WIDTH),
		.DATA_WIDTH(PS_LINE_BITS),
		.DEPTH(`PS_FIFO_DEPTH)
	) u_fifo (
		.clk(clk),
		.reset(reset),
		.push_line(push_line),
		.push_valid(push_valid),
		.push_ready(push_ready),
		.pop_line(pop_line),
		.pop_valid(pop_valid),
		.pop_ready(pop_ready),
		.fifo_full(fifo_full),
		.fifo_almost_full(fifo_almost_full),
		.fifo_empty(fifo_empty)
	);

	word_unpacker u_unpacker (
		.clk(clk),
		.reset(reset),
		.pop_line(pop_line),
		.pop_valid(pop_valid),
		.pop_ready(pop_ready),
		.out_word(out_word),
		.out_last(out_last),
		.out_sum(out_sum),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

endmodule

// File: hdl/word_packer.sv
// Producer stage that gathers accepted input words into line entries and pushes them into the FIFO
`timescale 1ns/1ps
`include "packet_stream_macros.svh"

module word_packer (
	input logic clk,
	input logic reset,

	// word input
	input packet_stream_pkg::ps_word_t in_word,
	input logic in_last,
	input logic in_valid,
	output logic in_ready,

	// line output toward the FIFO
	output packet_stream_pkg::ps_line_t push_line,
	output logic push_valid,
	input logic push_ready
);

	import packet_stream_pkg::*;

	pack_state_t state;
	logic [$clog2(`PS_LANES)-1:0] lane; // next lane to fill
	logic in_fire; // a word is taken this cycle
	logic line_done; // the accepted word closes the line

	assign in_ready = (state == PACK_FILL);
	assign push_valid = (state == PACK_PUSH);
	assign in_fire = in_valid && in_ready;
	assign line_done = in_last || (lane == $bits(lane)'(`PS_LANES - 1));

	// state and lane counter
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= PACK_FILL;
			lane <= '0;
		end else begin
			case (state)
				PACK_FILL: begin
					if (in_fire) begin
						if (line_done) begin
							state <= PACK_PUSH;
						end else begin
							lane <= lane + 1'b1;
						end
					end
				end
				PACK_PUSH: begin
					if (push_ready) begin
						state <= PACK_FILL; // line handed over, start a new one
						lane <= '0;
					end
				end
				default: state <= PACK_FILL;
			endcase
		end
	end

	// line payload, held steady while PACK_PUSH waits
	always_ff @(posedge clk) begin
		if (in_fire) begin
			push_line.lanes[lane] <= in_word;
			if (line_done) begin
				push_line.count <= lane; // lanes used minus one
				push_line.last <= in_last;
			end
		end
	end

endmodule

// File: hdl/word_unpacker.sv
// Consumer stage that pops line entries and emits their words with end-of-frame flag and frame sum
`timescale 1ns/1ps
`include "packet_stream_macros.svh"

module word_unpacker (
	input logic clk,
	input logic reset,

	// line input from the FIFO
	input packet_stream_pkg::ps_line_t pop_line,
	input logic pop_valid,
	output logic pop_ready,

	// word output
	output packet_stream_pkg::ps_word_t out_word,
	output logic out_last,
	output packet_stream_pkg::ps_sum_t out_sum,
	output logic out_valid,
	input logic out_ready
);

	import packet_stream_pkg::*;

	unpack_state_t state;
	ps_line_t line_q; // the line being handed out
	logic [$clog2(`PS_LANES)-1:0] idx; // lane currently on the output
	ps_sum_t sum_q; // sum of the frame words before the current one
	logic pop_fire;
	logic out_fire;
	logic final_lane; // current lane is the last valid one of the line

	assign pop_ready = (state == UNPACK_IDLE);
	assign pop_fire = pop_valid && pop_ready;

	assign out_valid = (state == UNPACK_EMIT);
	assign out_fire = out_valid && out_ready;

	assign final_lane = (idx == line_q.count);
	assign out_word = line_q.lanes[idx];
	assign out_last = final_lane && line_q.last;
	assign out_sum = sum_q + ps_sum_t'(out_word); // includes the word on the output

	// state, lane index and frame sum
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= UNPACK_IDLE;
			idx <= '0;
			sum_q <= '0;
		end else begin
			case (state)
				UNPACK_IDLE: begin
					if (pop_fire) begin
						state <= UNPACK_EMIT;
						idx <= '0;
					end
				end
				UNPACK_EMIT: begin
					if (out_fire) begin
						sum_q <= out_last ? '0 : out_sum; // a frame end restarts the sum
						if (final_lane) begin
							state <= UNPACK_IDLE;
						end else begin
							idx <= idx + 1'b1;
						end
					end
				end
				default: state <= UNPACK_IDLE;
			endcase
		end
	end

	// popped line payload
	always_ff @(posedge clk) begin
		if (pop_fire) begin
			line_q <= pop_line;
		end
	end

endmodule

// File: packet_stream.f
+incdir+hdl
hdl/packet_stream_pkg.sv
hdl/block_ram.sv
hdl/line_fifo.sv
hdl/word_packer.sv
hdl/word_unpacker.sv
hdl/packet_stream_top.sv
bench/packet_stream_tb.sv
